// ==== logic/mem_rdwr_pkg.sv ====
// ==========================================================
// Shared widths, bank depth and response codes for the
// split read/write memory path. Modules that need them
// pull them in with a wildcard import in their header.
// ==========================================================

`default_nettype none

package mem_rdwr_pkg;

    // Word address width, which covers more words than the bank holds
    localparam int ADDR_W = 8;

    // Data word width and the matching number of byte enables
    localparam int DATA_W = 32;
    localparam int BE_W = DATA_W / 8;

    // Number of words in the bank
    // Addresses from here up to the top of the address space are out of range
    localparam int BANK_DEPTH = 192;

    // Width of the Avalon response field
    localparam int RESP_W = 2;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [BE_W-1:0]   be_t;
    typedef logic [RESP_W-1:0] resp_t;

    // Avalon response encodings, only these two are ever produced
    localparam resp_t RESP_OKAY = 2'd0;
    localparam resp_t RESP_SLVERR = 2'd2;

endpackage

`default_nettype wire

// ==== logic/mem_rdwr_if.sv ====
// ==========================================================
// One split read/write Avalon link. The requester modport
// drives both request channels, and the responder modport
// drives waitrequest and the response strobes.
// ==========================================================

`default_nettype none
`timescale 1ns/1ns

interface mem_rdwr_if import mem_rdwr_pkg::*;
();

    // Read request channel
    logic  rd_read;
    addr_t rd_address;

    // Read response channel, a single-cycle strobe with no back-pressure
    logic  rd_waitrequest;
    logic  rd_readdatavalid;
    data_t rd_readdata;
    resp_t rd_response;

    // Write request channel
    logic  wr_write;
    addr_t wr_address;
    data_t wr_writedata;
    be_t   wr_byteenable;

    // Write response channel, also a single-cycle strobe
    logic  wr_waitrequest;
    logic  wr_writeresponsevalid;
    resp_t wr_response;

    // Side that issues requests and consumes responses
    modport requester
    (
        output rd_read, rd_address,
        output wr_write, wr_address, wr_writedata, wr_byteenable,
        input  rd_waitrequest, rd_readdatavalid, rd_readdata, rd_response,
        input  wr_waitrequest, wr_writeresponsevalid, wr_response
    );

    // Side that accepts requests and returns responses
    modport responder
    (
        input  rd_read, rd_address,
        input  wr_write, wr_address, wr_writedata, wr_byteenable,
        output rd_waitrequest, rd_readdatavalid, rd_readdata, rd_response,
        output wr_waitrequest, wr_writeresponsevalid, wr_response
    );

endinterface

`default_nettype wire

// ==== logic/mem_rdwr_stage.sv ====
// ==========================================================
// One pipeline stage for a split read/write Avalon link.
// Both request channels get a registered waitrequest backed
// by a one-entry skid buffer, and responses are registered.
// ==========================================================

`default_nettype none
`timescale 1ns/1ns

module mem_rdwr_stage import mem_rdwr_pkg::*;
(
    input  logic           clk,
    input  logic           arst_n,
    mem_rdwr_if.responder  up,
    mem_rdwr_if.requester  down
);

    // Read channel output register and skid entry
    logic  rd_out_valid;
    addr_t rd_out_address;
    logic  rd_skid_valid;
    addr_t rd_skid_address;
    logic  rd_accept;
    logic  rd_out_free;

    // Write channel output register and skid entry
    logic  wr_out_valid;
    addr_t wr_out_address;
    data_t wr_out_writedata;
    be_t   wr_out_byteenable;
    logic  wr_skid_valid;
    addr_t wr_skid_address;
    data_t wr_skid_writedata;
    be_t   wr_skid_byteenable;
    logic  wr_accept;
    logic  wr_out_free;

    // A request is taken whenever the skid entry is empty
    // Upstream only sees waitrequest once the skid entry is occupied
    assign rd_accept = up.rd_read && !rd_skid_valid;
    assign wr_accept = up.wr_write && !wr_skid_valid;

    // The output register can load when empty or when downstream takes it now
    assign rd_out_free = !rd_out_valid || !down.rd_waitrequest;
    assign wr_out_free = !wr_out_valid || !down.wr_waitrequest;

    assign up.rd_waitrequest = rd_skid_valid;
    assign up.wr_waitrequest = wr_skid_valid;

    assign down.rd_read = rd_out_valid;
    assign down.rd_address = rd_out_address;
    assign down.wr_write = wr_out_valid;
    assign down.wr_address = wr_out_address;
    assign down.wr_writedata = wr_out_writedata;
    assign down.wr_byteenable = wr_out_byteenable;

    // Request occupancy for both channels
    // A held skid entry always drains first, so ordering is kept
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rd_out_valid <= 1'b0;
            rd_skid_valid <= 1'b0;
            wr_out_valid <= 1'b0;
            wr_skid_valid <= 1'b0;
        end
        else
        begin
            if (rd_out_free)
            begin
                rd_out_valid <= rd_skid_valid || rd_accept;
                rd_skid_valid <= 1'b0;
            end
            else if (rd_accept)
            begin
                // Downstream is stalled, so park the new request
                rd_skid_valid <= 1'b1;
            end

            if (wr_out_free)
            begin
                wr_out_valid <= wr_skid_valid || wr_accept;
                wr_skid_valid <= 1'b0;
            end
            else if (wr_accept)
            begin
                wr_skid_valid <= 1'b1;
            end
        end
    end

    // Request payload follows the occupancy bits above
    // The skid copy is only looked at while its valid bit is set
    always_ff @(posedge clk)
    begin
        if (rd_out_free)
        begin
            rd_out_address <= rd_skid_valid ? rd_skid_address : up.rd_address;
        end
        if (rd_accept)
        begin
            rd_skid_address <= up.rd_address;
        end

        if (wr_out_free)
        begin
            wr_out_address <= wr_skid_valid ? wr_skid_address : up.wr_address;
            wr_out_writedata <= wr_skid_valid ? wr_skid_writedata : up.wr_writedata;
            wr_out_byteenable <= wr_skid_valid ? wr_skid_byteenable : up.wr_byteenable;
        end
        if (wr_accept)
        begin
            wr_skid_address <= up.wr_address;
            wr_skid_writedata <= up.wr_writedata;
            wr_skid_byteenable <= up.wr_byteenable;
        end
    end

    // Response strobes are delayed by one cycle
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            up.rd_readdatavalid <= 1'b0;
            up.wr_writeresponsevalid <= 1'b0;
        end
        else
        begin
            up.rd_readdatavalid <= down.rd_readdatavalid;
            up.wr_writeresponsevalid <= down.wr_writeresponsevalid;
        end
    end

    // Response payload travels alongside its strobe
    always_ff @(posedge clk)
    begin
        up.rd_readdata <= down.rd_readdata;
        up.rd_response <= down.rd_response;
        up.wr_response <= down.wr_response;
    end

endmodule

`default_nettype wire

// ==== logic/mem_rdwr_reg.sv ====
// ==========================================================
// Inserts a configurable chain of register stages between
// two split read/write links. Each stage adds one cycle to
// requests and one to responses, and zero stages add none.
// ==========================================================

`default_nettype none
`timescale 1ns/1ns

module mem_rdwr_reg
#(
    parameter int N_REG_STAGES = 2
)
(
    input  logic           clk,
    input  logic           arst_n,
    mem_rdwr_if.responder  sink,
    mem_rdwr_if.requester  source
);

    // Link 0 faces the sink and link N_REG_STAGES faces the source
    // With zero stages both are the same link, which makes a direct connection
    mem_rdwr_if link[N_REG_STAGES+1]();

    // Requests enter the chain on link 0
    assign link[0].rd_read = sink.rd_read;
    assign link[0].rd_address = sink.rd_address;
    assign link[0].wr_write = sink.wr_write;
    assign link[0].wr_address = sink.wr_address;
    assign link[0].wr_writedata = sink.wr_writedata;
    assign link[0].wr_byteenable = sink.wr_byteenable;

    // Waitrequest and responses leave the chain from link 0
    assign sink.rd_waitrequest = link[0].rd_waitrequest;
    assign sink.rd_readdatavalid = link[0].rd_readdatavalid;
    assign sink.rd_readdata = link[0].rd_readdata;
    assign sink.rd_response = link[0].rd_response;
    assign sink.wr_waitrequest = link[0].wr_waitrequest;
    assign sink.wr_writeresponsevalid = link[0].wr_writeresponsevalid;
    assign sink.wr_response = link[0].wr_response;

    // Requests leave the chain from the last link
    assign source.rd_read = link[N_REG_STAGES].rd_read;
    assign source.rd_address = link[N_REG_STAGES].rd_address;
    assign source.wr_write = link[N_REG_STAGES].wr_write;
    assign source.wr_address = link[N_REG_STAGES].wr_address;
    assign source.wr_writedata = link[N_REG_STAGES].wr_writedata;
    assign source.wr_byteenable = link[N_REG_STAGES].wr_byteenable;

    // Responses from the source enter at the last link
    assign link[N_REG_STAGES].rd_waitrequest = source.rd_waitrequest;
    assign link[N_REG_STAGES].rd_readdatavalid = source.rd_readdatavalid;
    assign link[N_REG_STAGES].rd_readdata = source.rd_readdata;
    assign link[N_REG_STAGES].rd_response = source.rd_response;
    assign link[N_REG_STAGES].wr_waitrequest = source.wr_waitrequest;
    assign link[N_REG_STAGES].wr_writeresponsevalid = source.wr_writeresponsevalid;
    assign link[N_REG_STAGES].wr_response = source.wr_response;

    // Stage s sits between link s and link s+1
    for (genvar s = 0; s < N_REG_STAGES; s++)
    begin : g_stage
        mem_rdwr_stage u_stage
        (
            .clk    (clk),
            .arst_n (arst_n),
            .up     (link[s]),
            .down   (link[s+1])
        );
    end

endmodule

`default_nettype wire

// ==== logic/mem_bank.sv ====
// ==========================================================
// Single-ported memory bank behind a split read/write link.
// One access per cycle with the write taking priority, and
// every response strobe follows acceptance by one cycle.
// ==========================================================

`default_nettype none
`timescale 1ns/1ns

module mem_bank import mem_rdwr_pkg::*;
(
    input  logic           clk,
    input  logic           arst_n,
    mem_rdwr_if.responder  bus
);

    // Word storage, addressed directly by the in-range word address
    data_t mem [BANK_DEPTH];

    logic rd_accept;
    logic wr_accept;
    logic rd_in_range;
    logic wr_in_range;

    // A write always wins the single port
    // The read is held off only in cycles where both channels present
    assign bus.rd_waitrequest = bus.rd_read && bus.wr_write;
    assign bus.wr_waitrequest = 1'b0;

    assign wr_accept = bus.wr_write;
    assign rd_accept = bus.rd_read && !bus.wr_write;

    assign rd_in_range = bus.rd_address < BANK_DEPTH;
    assign wr_in_range = bus.wr_address < BANK_DEPTH;

    // Write port with byte-enable merge
    // Out-of-range writes are dropped here and flagged in the response
    always_ff @(posedge clk)
    begin
        if (wr_accept && wr_in_range)
        begin
            for (int b = 0; b < BE_W; b++)
            begin
                if (bus.wr_byteenable[b])
                begin
                    mem[bus.wr_address][8*b +: 8] <= bus.wr_writedata[8*b +: 8];
                end
            end
        end
    end

    // Read data and both response codes, one cycle after acceptance
    always_ff @(posedge clk)
    begin
        if (rd_accept)
        begin
            bus.rd_readdata <= rd_in_range ? mem[bus.rd_address] : '0;
            bus.rd_response <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
        end
        if (wr_accept)
        begin
            bus.wr_response <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // Response strobes
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            bus.rd_readdatavalid <= 1'b0;
            bus.wr_writeresponsevalid <= 1'b0;
        end
        else
        begin
            bus.rd_readdatavalid <= rd_accept;
            bus.wr_writeresponsevalid <= wr_accept;
        end
    end

endmodule

`default_nettype wire

// ==== logic/mem_rdwr_top.sv ====
// ==========================================================
// Top level of the split read/write memory path. Plain
// Avalon ports feed the register stage chain, which in turn
// feeds the memory bank.
// ==========================================================

`default_nettype none
`timescale 1ns/1ns

module mem_rdwr_top import mem_rdwr_pkg::*;
#(
    parameter int N_REG_STAGES = 2
)
(
    input  logic  clk,
    input  logic  arst_n,

    // Read channel
    input  logic  rd_read,
    input  addr_t rd_address,
    output logic  rd_waitrequest,
    output logic  rd_readdatavalid,
    output data_t rd_readdata,
    output resp_t rd_response,

    // Write channel
    input  logic  wr_write,
    input  addr_t wr_address,
    input  data_t wr_writedata,
    input  be_t   wr_byteenable,
    output logic  wr_waitrequest,
    output logic  wr_writeresponsevalid,
    output resp_t wr_response
);

    // Link at the pins and link in front of the bank
    mem_rdwr_if top_link();
    mem_rdwr_if bank_link();

    // Pins onto the top link
    assign top_link.rd_read = rd_read;
    assign top_link.rd_address = rd_address;
    assign top_link.wr_write = wr_write;
    assign top_link.wr_address = wr_address;
    assign top_link.wr_writedata = wr_writedata;
    assign top_link.wr_byteenable = wr_byteenable;

    assign rd_waitrequest = top_link.rd_waitrequest;
    assign rd_readdatavalid = top_link.rd_readdatavalid;
    assign rd_readdata = top_link.rd_readdata;
    assign rd_response = top_link.rd_response;
    assign wr_waitrequest = top_link.wr_waitrequest;
    assign wr_writeresponsevalid = top_link.wr_writeresponsevalid;
    assign wr_response = top_link.wr_response;

    mem_rdwr_reg #(.N_REG_STAGES(N_REG_STAGES)) u_mem_rdwr_reg
    (
        .clk    (clk),
        .arst_n (arst_n),
        .sink   (top_link),
        .source (bank_link)
    );

    mem_bank u_mem_bank
    (
        .clk    (clk),
        .arst_n (arst_n),
        .bus    (bank_link)
    );

endmodule

`default_nettype wire

// ==== bench/mem_rdwr_checker.sv ====
// ==========================================================
// Scoreboard for the memory path testbench. Watches the top
// level ports, models the bank and compares every response
// strobe with the response expected for its request.
// ==========================================================

`default_nettype none
`timescale 1ns/1ns

module mem_rdwr_checker import mem_rdwr_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       rd_read,
    input  addr_t      rd_address,
    input  logic       rd_waitrequest,
    input  logic       rd_readdatavalid,
    input  data_t      rd_readdata,
    input  resp_t      rd_response,
    input  logic       wr_write,
    input  addr_t      wr_address,
    input  data_t      wr_writedata,
    input  be_t        wr_byteenable,
    input  logic       wr_waitrequest,
    input  logic       wr_writeresponsevalid,
    input  resp_t      wr_response,
    input  logic [2:0] test_num,
    output int         pending
);

    // Reference copy of the bank contents
    data_t ref_mem [BANK_DEPTH];

    // Expected responses of each channel with the oldest at the front
    data_t rd_exp_data [$];
    resp_t rd_exp_resp [$];
    int    rd_exp_test [$];
    resp_t wr_exp_resp [$];
    int    wr_exp_test [$];

    int error_count = 0;
    int rd_accepted = 0;
    int rd_returned = 0;
    int wr_accepted = 0;
    int wr_returned = 0;

    // Edges since reset release, saturating at three
    // It starts saturated so that edges before the first reset are not checked
    int after_reset = 3;

    // Enabled bytes of a write replace the matching bytes of the old word
    function automatic data_t merge_word(data_t old_word, data_t new_word, be_t be);
        data_t result;
        result = old_word;
        for (int b = 0; b < BE_W; b++)
        begin
            if (be[b])
            begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    // Anything at or past the bank depth is an error response
    function automatic resp_t range_resp(addr_t a);
        return (a < BANK_DEPTH) ? RESP_OKAY : RESP_SLVERR;
    endfunction

    // Out-of-range reads return zero data
    function automatic data_t expected_read(addr_t a);
        return (a < BANK_DEPTH) ? ref_mem[a] : '0;
    endfunction

    function automatic string test_label(int t);
        case (t)
            1: return "reset";
            2: return "full_write";
            3: return "partial_write";
            4: return "out_of_range";
            5: return "random_stream";
            default: return "unknown";
        endcase
    endfunction

    always @(posedge clk)
    begin : compare
        data_t exp_data;
        resp_t exp_resp;
        int    t;

        // Handshake outputs must stay quiet in reset and for three cycles after
        if (!arst_n || after_reset < 3)
        begin
            if ({rd_waitrequest, rd_readdatavalid, wr_waitrequest, wr_writeresponsevalid}
                !== 4'b0000)
            begin
                $display("ERROR: a waitrequest or response strobe was not low around reset");
                error_count++;
            end
        end
        if (!arst_n)
        begin
            after_reset = 0;
        end
        else if (after_reset < 3)
        begin
            after_reset++;
        end

        if (arst_n)
        begin
            // Writes are recorded first since the bank serves them ahead of reads
            if (wr_write && !wr_waitrequest)
            begin
                if (wr_address < BANK_DEPTH)
                begin
                    ref_mem[wr_address] = merge_word(ref_mem[wr_address], wr_writedata,
                                                     wr_byteenable);
                end
                wr_exp_resp.push_back(range_resp(wr_address));
                wr_exp_test.push_back(test_num);
                wr_accepted++;
            end
            if (rd_read && !rd_waitrequest)
            begin
                rd_exp_data.push_back(expected_read(rd_address));
                rd_exp_resp.push_back(range_resp(rd_address));
                rd_exp_test.push_back(test_num);
                rd_accepted++;
            end

            if (wr_writeresponsevalid)
            begin
                wr_returned++;
                if (wr_exp_resp.size() == 0)
                begin
                    $display("ERROR: write response strobe with no write outstanding");
                    error_count++;
                end
                else
                begin
                    exp_resp = wr_exp_resp.pop_front();
                    t = wr_exp_test.pop_front();
                    if (wr_response !== exp_resp)
                    begin
                        $display("[FAIL] %s wr_response: expected %0d, actual %0d",
                                 test_label(t), exp_resp, wr_response);
                        error_count++;
                    end
                end
            end

            if (rd_readdatavalid)
            begin
                rd_returned++;
                if (rd_exp_data.size() == 0)
                begin
                    $display("ERROR: read data strobe with no read outstanding");
                    error_count++;
                end
                else
                begin
                    exp_data = rd_exp_data.pop_front();
                    exp_resp = rd_exp_resp.pop_front();
                    t = rd_exp_test.pop_front();
                    if (rd_readdata !== exp_data)
                    begin
                        $display("[FAIL] %s rd_readdata: expected %h, actual %h",
                                 test_label(t), exp_data, rd_readdata);
                        error_count++;
                    end
                    if (rd_response !== exp_resp)
                    begin
                        $display("[FAIL] %s rd_response: expected %0d, actual %0d",
                                 test_label(t), exp_resp, rd_response);
                        error_count++;
                    end
                end
            end
        end

        pending = rd_exp_data.size() + wr_exp_resp.size();
    end

    // End-of-run checks and the closing count line
    task finish_checks(output int total);
        if (rd_exp_data.size() != 0)
        begin
            $display("ERROR: %0d read responses never arrived", rd_exp_data.size());
            error_count++;
        end
        if (wr_exp_resp.size() != 0)
        begin
            $display("ERROR: %0d write responses never arrived", wr_exp_resp.size());
            error_count++;
        end
        $display("Checker: %0d errors, reads %0d/%0d, writes %0d/%0d (accepted/returned)",
                 error_count, rd_accepted, rd_returned, wr_accepted, wr_returned);
        total = error_count;
    endtask

endmodule

`default_nettype wire

// ==== bench/mem_rdwr_tb.sv ====
// ==========================================================
// Testbench top for the split read/write memory path.
// Drives reset and requests through the top level ports and
// leaves all comparing to the checker instance.
// ==========================================================

`default_nettype none
`timescale 1ns/1ns

module mem_rdwr_tb import mem_rdwr_pkg::*;
();

    localparam int N_STAGES = 2;
    localparam int CLK_PERIOD = 40;

    // Request counts of each test
    localparam int N_FULL = 32;
    localparam int N_PART = 8;
    localparam int N_OOR = 3;
    localparam int N_RAND = 48;
    localparam int TOTAL_REQS = 2*N_FULL + 2*N_PART + 3*N_OOR + 2*N_RAND;

    // Every request gets its uncontended latency plus a few cycles of slack
    localparam int TIMEOUT_NS = TOTAL_REQS * (2*N_STAGES + 4) * CLK_PERIOD + 50 * CLK_PERIOD;

    logic       clk = 1'b0;
    logic       arst_n;
    logic       rd_read;
    addr_t      rd_address;
    logic       rd_waitrequest;
    logic       rd_readdatavalid;
    data_t      rd_readdata;
    resp_t      rd_response;
    logic       wr_write;
    addr_t      wr_address;
    data_t      wr_writedata;
    be_t        wr_byteenable;
    logic       wr_waitrequest;
    logic       wr_writeresponsevalid;
    resp_t      wr_response;
    logic [2:0] test_num;
    int         pending;
    int         seed = 32'h9a38_87e0;

    always #(CLK_PERIOD/2) clk = ~clk;

    mem_rdwr_top #(.N_REG_STAGES(N_STAGES)) u_mem_rdwr_top (.*);

    mem_rdwr_checker u_check (.*);

    // Present a read and hold it until waitrequest is low at a rising edge
    task automatic issue_read(input addr_t a);
        @(negedge clk);
        rd_read = 1'b1;
        rd_address = a;
        @(posedge clk);
        while (rd_waitrequest)
        begin
            @(posedge clk);
        end
    endtask

    task automatic issue_write(input addr_t a, input data_t d, input be_t be);
        @(negedge clk);
        wr_write = 1'b1;
        wr_address = a;
        wr_writedata = d;
        wr_byteenable = be;
        @(posedge clk);
        while (wr_waitrequest)
        begin
            @(posedge clk);
        end
    endtask

    // Drop both requests and wait for every outstanding response
    task automatic drain();
        @(negedge clk);
        rd_read = 1'b0;
        wr_write = 1'b0;
        while (pending != 0)
        begin
            @(negedge clk);
        end
    endtask

    initial
    begin : stimulus
        int errs;

        rd_read = 1'b0;
        rd_address = '0;
        wr_write = 1'b0;
        wr_address = '0;
        wr_writedata = '0;
        wr_byteenable = '0;
        test_num = 3'd1;
        arst_n = 1'b1;
        // Hold reset for three clock cycles
        @(negedge clk);
        arst_n = 1'b0;
        repeat (3) @(negedge clk);
        arst_n = 1'b1;
        // Idle cycles so the checker sees the quiet period after reset
        repeat (4) @(negedge clk);

        // Full-word writes followed by a read of every word
        test_num = 3'd2;
        for (int i = 0; i < N_FULL; i++)
        begin
            issue_write(addr_t'(i), $random(seed), '1);
        end
        drain();
        for (int i = 0; i < N_FULL; i++)
        begin
            issue_read(addr_t'(i));
        end
        drain();

        // Random byte enables over words that already hold known data
        test_num = 3'd3;
        for (int i = 0; i < N_PART; i++)
        begin
            issue_write(addr_t'(i), $random(seed), be_t'($random(seed)));
        end
        drain();
        for (int i = 0; i < N_PART; i++)
        begin
            issue_read(addr_t'(i));
        end
        drain();

        // Out-of-range accesses and reads of the words they would alias onto
        test_num = 3'd4;
        for (int i = 0; i < N_OOR; i++)
        begin
            issue_write(addr_t'(BANK_DEPTH + 15*i), $random(seed), '1);
        end
        drain();
        for (int i = 0; i < N_OOR; i++)
        begin
            issue_read(addr_t'(BANK_DEPTH + 15*i));
        end
        for (int i = 0; i < N_OOR; i++)
        begin
            issue_read(addr_t'(15*i));
        end
        drain();

        // Reads of the low words race writes into a disjoint upper range
        test_num = 3'd5;
        fork
            begin
                for (int i = 0; i < N_RAND; i++)
                begin
                    issue_read(addr_t'({$random(seed)} % N_FULL));
                end
                @(negedge clk);
                rd_read = 1'b0;
            end
            begin
                for (int i = 0; i < N_RAND; i++)
                begin
                    issue_write(addr_t'(64 + {$random(seed)} % 64), $random(seed), '1);
                end
                @(negedge clk);
                wr_write = 1'b0;
            end
        join
        drain();

        u_check.finish_checks(errs);
        if (errs == 0)
        begin
            $display(">>> PASS");
        end
        else
        begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial
    begin : watchdog
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns, a request or response is stuck", TIMEOUT_NS);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
logic/mem_rdwr_pkg.sv
logic/mem_rdwr_if.sv
logic/mem_rdwr_stage.sv
logic/mem_rdwr_reg.sv
logic/mem_bank.sv
logic/mem_rdwr_top.sv
bench/mem_rdwr_checker.sv
bench/mem_rdwr_tb.sv

// ==== Bender.yml ====
package:
  name: mem_rdwr

sources:
  - target: any(rtl, test)
    files:
      - logic/mem_rdwr_pkg.sv
      - logic/mem_rdwr_if.sv
      - logic/mem_rdwr_stage.sv
      - logic/mem_rdwr_reg.sv
      - logic/mem_bank.sv
      - logic/mem_rdwr_top.sv
  - target: test
    files:
      - bench/mem_rdwr_checker.sv
      - bench/mem_rdwr_tb.sv
